// ==== vlog.f ====
design/chan_pkg.sv
design/link_if.sv
design/command_proc.sv
design/fill_reader.sv
design/tx_arbiter.sv
design/channel_core.sv
dv/chan_clk_gen.sv
dv/chan_assert.sv
dv/chan_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= chan_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/chan_tb.sv ====
`timescale 1ns/100ps

module chan_tb;

  localparam int total_words = 41; // tag 1, fill 13, pause 17, fill then tag 10
  localparam int wd_cycles   = total_words * 20 + chan_pkg::mem_depth + 300; // + memory load

  logic                              clk125;
  logic                              arst_n;
  logic [chan_pkg::word_w-1:0]       rx_data;
  logic                              rx_valid;
  logic                              rx_last;
  logic                              rx_ready;
  logic [chan_pkg::word_w-1:0]       tx_data;
  logic                              tx_valid;
  logic                              tx_last;
  logic                              tx_ready;
  logic                              readout_pause;
  logic                              mem_wr_en;
  logic [chan_pkg::mem_addr_w-1:0]   mem_wr_addr;
  logic [chan_pkg::burst_w-1:0]      mem_wr_data;

  logic [chan_pkg::burst_w-1:0] mem_model [chan_pkg::mem_depth]; // what was written
  logic [chan_pkg::tag_w-1:0]   tag_model;
  logic [chan_pkg::word_w:0]    exp_q [$];    // {last, data} in tx order
  logic                         bp_on = 1'b0; // random tx back-pressure
  string                        test_name;
  int                           test_errs;
  int                           tests_run;
  int                           tests_failed;
  int unsigned                  assert_base;  // assertion failures before this test

  chan_clk_gen i_clk_gen (.clk125 (clk125), .arst_n (arst_n));

  channel_core i_dut (
    .clk125 (clk125), .arst_n (arst_n),
    .rx_data (rx_data), .rx_valid (rx_valid), .rx_last (rx_last), .rx_ready (rx_ready),
    .tx_data (tx_data), .tx_valid (tx_valid), .tx_last (tx_last), .tx_ready (tx_ready),
    .readout_pause (readout_pause),
    .mem_wr_en (mem_wr_en), .mem_wr_addr (mem_wr_addr), .mem_wr_data (mem_wr_data)
  );

  ///////////////////////////////////////////////////
  // stimulus helpers, all driven on the falling edge
  ///////////////////////////////////////////////////
  task automatic send_cmd(input logic [chan_pkg::word_w-1:0] word);
    @(negedge clk125);
    rx_data  = word;
    rx_valid = 1'b1;
    rx_last  = 1'b1; // single-word packets
    #1;
    while (!rx_ready) begin
      @(negedge clk125);
      #1;
    end
    @(negedge clk125); // taken on the rising edge in between
    rx_valid = 1'b0;
  endtask

  task automatic write_burst(input logic [5:0] addr, input logic [chan_pkg::burst_w-1:0] data);
    @(negedge clk125);
    mem_wr_en   = 1'b1;
    mem_wr_addr = addr;
    mem_wr_data = data;
    mem_model[addr] = data;
  endtask

  // header, then 4 words per burst from ascending addresses, low word first
  task automatic read_fill(input logic [5:0] start, input int bursts);
    logic [5:0] a;
    exp_q.push_back({1'b0, chan_pkg::resp_fill, tag_model, 1'b0, 7'(bursts)});
    for (int b = 0; b < bursts; b++) begin
      a = start + 6'(b); // wraps like the memory
      for (int w = 0; w < chan_pkg::words_per_burst; w++) begin
        exp_q.push_back({1'((b == bursts - 1) && (w == chan_pkg::words_per_burst - 1)),
                         mem_model[a][chan_pkg::word_w*w +: chan_pkg::word_w]});
      end
    end
    send_cmd({chan_pkg::op_read_fill, 2'b00, start, 9'h000, 7'(bursts)});
  endtask

  task automatic check_word(input logic last, input logic [chan_pkg::word_w-1:0] data);
    logic [chan_pkg::word_w:0] exp_word;
    if (exp_q.size() == 0) begin
      $display("%s: tx word %h arrived when no word was expected", test_name, data);
      test_errs++;
    end else begin
      exp_word = exp_q.pop_front();
      assert ({last, data} == exp_word) else begin
        $display("[ERROR] %s: expected %h last %b, actual %h last %b", test_name,
                 exp_word[chan_pkg::word_w-1:0], exp_word[chan_pkg::word_w], data, last);
        test_errs++;
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errs   = 0;
    assert_base = i_dut.i_chan_assert.fail_cnt;
  endtask

  task automatic end_test();
    int errs;
    while (exp_q.size() != 0) @(negedge clk125);
    repeat (8) @(negedge clk125); // room for a stray or repeated word
    errs = test_errs + int'(i_dut.i_chan_assert.fail_cnt - assert_base);
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %s: %s (%0d errors)", test_name, (errs == 0) ? "PASS" : "FAIL", errs);
  endtask

  ///////////////////////////////////////////////////
  // tx side: ready pattern and word monitor
  ///////////////////////////////////////////////////
  initial begin
    tx_ready = 1'b1;
    forever begin
      @(negedge clk125);
      tx_ready = bp_on ? 1'($urandom_range(1, 0)) : 1'b1;
    end
  end

  initial begin
    forever begin
      @(negedge clk125);
      #1; // inputs settled, transfer happens on the next rising edge
      if (arst_n && tx_valid && tx_ready) check_word(tx_last, tx_data);
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clk125);
    $display("watchdog: run still busy after %0d cycles, a response never ended", wd_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h5180_8922));
    rx_data       = '0;
    rx_valid      = 1'b0;
    rx_last       = 1'b0;
    readout_pause = 1'b0;
    mem_wr_en     = 1'b0;
    mem_wr_addr   = '0;
    mem_wr_data   = '0;
    tag_model     = '0; // matches the tag after reset
    tests_run     = 0;
    tests_failed  = 0;
    @(posedge arst_n);

    begin_test("reset");
    end_test();

    begin_test("tag_rw");
    tag_model = 16'($urandom);
    send_cmd({chan_pkg::op_write_tag, 8'h00, tag_model});
    send_cmd({8'h5a, 24'h00_0000}); // unknown opcode, no reply
    exp_q.push_back({1'b1, chan_pkg::resp_tag, 8'h00, tag_model});
    send_cmd({chan_pkg::op_read_tag, 24'h00_0000});
    end_test();

    begin_test("fill_backpressure");
    for (int a = 0; a < chan_pkg::mem_depth; a++) begin
      write_burst(6'(a), {$urandom, $urandom, $urandom, $urandom});
    end
    @(negedge clk125);
    mem_wr_en = 1'b0;
    bp_on     = 1'b1;
    read_fill(6'($urandom), 3);
    end_test();
    bp_on = 1'b0;

    begin_test("readout_pause");
    read_fill(6'($urandom), 4);
    while (exp_q.size() > 10) @(negedge clk125); // mid fill
    readout_pause = 1'b1;
    repeat (12) @(negedge clk125);
    readout_pause = 1'b0;
    end_test();

    begin_test("fill_then_tag");
    read_fill(6'($urandom), 2);
    exp_q.push_back({1'b1, chan_pkg::resp_tag, 8'h00, tag_model});
    send_cmd({chan_pkg::op_read_tag, 24'h00_0000}); // taken as soon as the fill ends
    end_test();

    $display("summary: %0d run, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== dv/chan_assert.sv ====
`timescale 1ns/100ps

module chan_assert (
  input logic                        clk125,
  input logic                        arst_n,
  input logic [chan_pkg::word_w-1:0] rx_data,
  input logic                        rx_valid,
  input logic                        rx_ready,
  input logic [chan_pkg::word_w-1:0] tx_data,
  input logic                        tx_valid,
  input logic                        tx_last,
  input logic                        tx_ready,
  input logic                        readout_pause,
  input logic                        use_fill_data
);

  int unsigned               fail_cnt = 0; // bumped by every failing assertion
  logic                      await_last;   // responding command taken, final word not yet out
  logic [chan_pkg::op_w-1:0] rx_op;

  assign rx_op = rx_data[chan_pkg::op_lo +: chan_pkg::op_w];

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      await_last <= 1'b0;
    end else if (rx_valid && rx_ready &&
                 (rx_op == chan_pkg::op_read_tag || rx_op == chan_pkg::op_read_fill)) begin
      await_last <= 1'b1;
    end else if (tx_valid && tx_ready && tx_last) begin
      await_last <= 1'b0; // response complete
    end
  end

  ///////////////////////////////////////////////////
  // link rules
  ///////////////////////////////////////////////////
  reset_state_a: assert property (@(posedge clk125)
    $rose(arst_n) |-> !tx_valid && rx_ready && !use_fill_data)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("link not idle right after reset release");
    end

  // word held under back-pressure
  tx_hold_a: assert property (@(posedge clk125) disable iff (!arst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("tx word changed or dropped while stalled");
    end

  // two sync flops, so the link freezes 2 cycles after pause and thaws 2 after release
  pause_a: assert property (@(posedge clk125) disable iff (!arst_n)
    $past(readout_pause, 2) |-> !tx_valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("tx word offered during readout pause");
    end

  rx_busy_a: assert property (@(posedge clk125) disable iff (!arst_n)
    await_last |-> !rx_ready)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("rx accepted a command before the response ended");
    end

  rx_free_a: assert property (@(posedge clk125) disable iff (!arst_n)
    tx_valid && tx_ready && tx_last |=> rx_ready)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("rx still busy after the final response word");
    end

endmodule

bind channel_core chan_assert i_chan_assert (
  .clk125        (clk125),
  .arst_n        (arst_n),
  .rx_data       (rx_data),
  .rx_valid      (rx_valid),
  .rx_ready      (rx_ready),
  .tx_data       (tx_data),
  .tx_valid      (tx_valid),
  .tx_last       (tx_last),
  .tx_ready      (tx_ready),
  .readout_pause (readout_pause),
  .use_fill_data (use_fill_data)
);

// ==== dv/chan_clk_gen.sv ====
`timescale 1ns/100ps

// 125 MHz clock and power-on reset for the channel testbench
module chan_clk_gen (
  output logic clk125,
  output logic arst_n
);

  localparam int reset_cycles = 10;

  initial begin
    clk125 = 1'b0;
    forever #4 clk125 = ~clk125; // 8 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk125);
    @(negedge clk125);
    arst_n = 1'b1; // released between edges
  end

endmodule

// ==== design/channel_core.sv ====
`timescale 1ns/100ps

module channel_core (
  input  logic                            clk125,
  input  logic                            arst_n,
  // link receive stream
  input  logic [chan_pkg::word_w-1:0]     rx_data,
  input  logic                            rx_valid,
  input  logic                            rx_last,
  output logic                            rx_ready,
  // link transmit stream
  output logic [chan_pkg::word_w-1:0]     tx_data,
  output logic                            tx_valid,
  output logic                            tx_last,
  input  logic                            tx_ready,
  input  logic                            readout_pause,
  // fill memory write port, stands in for the acquisition side
  input  logic                            mem_wr_en,
  input  logic [chan_pkg::mem_addr_w-1:0] mem_wr_addr,
  input  logic [chan_pkg::burst_w-1:0]    mem_wr_data
);

  link_if cmd_link ();  // command responses
  link_if fill_link (); // fill words

  logic                             read_start;
  logic [chan_pkg::mem_addr_w-1:0]  start_addr;
  logic [chan_pkg::burst_cnt_w-1:0] burst_cnt;
  logic                             reading_done;
  logic                             use_fill_data;

  ///////////////////////////////////////////////////
  // command processor and fill reader are peers on the link
  ///////////////////////////////////////////////////
  command_proc i_command_proc (
    .clk125        (clk125),
    .arst_n        (arst_n),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_last       (rx_last),
    .rx_ready      (rx_ready),
    .cmd_link      (cmd_link.src),
    .read_start    (read_start),
    .start_addr    (start_addr),
    .burst_cnt     (burst_cnt),
    .reading_done  (reading_done),
    .use_fill_data (use_fill_data)
  );

  fill_reader i_fill_reader (
    .clk125       (clk125),
    .arst_n       (arst_n),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .read_start   (read_start),
    .start_addr   (start_addr),
    .burst_cnt    (burst_cnt),
    .fill_link    (fill_link.src),
    .reading_done (reading_done)
  );

  tx_arbiter i_tx_arbiter (
    .clk125        (clk125),
    .arst_n        (arst_n),
    .readout_pause (readout_pause),
    .use_fill_data (use_fill_data),
    .cmd_link      (cmd_link.snk),
    .fill_link     (fill_link.snk),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_last       (tx_last),
    .tx_ready      (tx_ready)
  );

endmodule

// ==== design/tx_arbiter.sv ====
`timescale 1ns/100ps

module tx_arbiter (
  input  logic                        clk125,
  input  logic                        arst_n,
  input  logic                        readout_pause, // async level from the master
  input  logic                        use_fill_data,
  link_if.snk                         cmd_link,
  link_if.snk                         fill_link,
  output logic [chan_pkg::word_w-1:0] tx_data,
  output logic                        tx_valid,
  output logic                        tx_last,
  input  logic                        tx_ready
);

  logic pause_meta;
  logic pause_sync;
  logic link_go;

  // two-flop synchronizer, comes up not paused
  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      pause_meta <= 1'b0;
      pause_sync <= 1'b0;
    end else begin
      pause_meta <= readout_pause;
      pause_sync <= pause_meta;
    end
  end

  ///////////////////////////////////////////////////
  // 2:1 select, command data unless the fill owns the link
  ///////////////////////////////////////////////////
  assign tx_data  = use_fill_data ? fill_link.data : cmd_link.data;
  assign tx_last  = use_fill_data ? fill_link.last : cmd_link.last;
  assign tx_valid = !pause_sync && (use_fill_data ? fill_link.valid : cmd_link.valid);

  assign link_go = tx_ready && !pause_sync; // pause freezes both sources

  // only the selected source sees ready
  assign fill_link.ready = use_fill_data && link_go;
  assign cmd_link.ready  = !use_fill_data && link_go;

endmodule

// ==== design/fill_reader.sv ====
`timescale 1ns/100ps

module fill_reader (
  input  logic                             clk125,
  input  logic                             arst_n,
  input  logic                             mem_wr_en,
  input  logic [chan_pkg::mem_addr_w-1:0]  mem_wr_addr,
  input  logic [chan_pkg::burst_w-1:0]     mem_wr_data,
  input  logic                             read_start,
  input  logic [chan_pkg::mem_addr_w-1:0]  start_addr,
  input  logic [chan_pkg::burst_cnt_w-1:0] burst_cnt,
  link_if.src                              fill_link,
  output logic                             reading_done
);

  logic [chan_pkg::burst_w-1:0]     mem [chan_pkg::mem_depth];
  logic [chan_pkg::burst_w-1:0]     pre_data;   // next burst, straight from the memory read
  logic                             pre_valid;
  logic [chan_pkg::burst_w-1:0]     cur_data;   // burst being split, low word at the bottom
  logic                             cur_valid;
  logic [chan_pkg::word_idx_w-1:0]  word_idx;
  logic [chan_pkg::mem_addr_w-1:0]  rd_addr;    // next burst to fetch
  logic [chan_pkg::mem_addr_w-1:0]  addr_sel;
  logic [chan_pkg::burst_cnt_w-1:0] fetch_left; // bursts not yet fetched
  logic                             xfer;
  logic                             word_end;
  logic                             load_cur;
  logic                             issue;

  ///////////////////////////////////////////////////
  // fetch side
  ///////////////////////////////////////////////////
  assign xfer     = cur_valid && fill_link.ready;
  assign word_end = xfer && (word_idx == chan_pkg::last_word);
  assign load_cur = pre_valid && (!cur_valid || word_end); // prefetch moves down

  // read when the prefetch slot is free after this edge
  assign issue    = read_start || ((fetch_left != '0) && (!pre_valid || load_cur));
  assign addr_sel = read_start ? start_addr : rd_addr;

  // memory with one cycle of read latency, into the prefetch register
  always_ff @(posedge clk125) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr] <= mem_wr_data;
    end
    if (issue) begin
      pre_data <= mem[addr_sel];
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      rd_addr    <= '0;
      fetch_left <= '0;
      pre_valid  <= 1'b0;
    end else begin
      if (issue) begin
        rd_addr    <= addr_sel + 1'b1; // wraps at the top of memory
        fetch_left <= (read_start ? burst_cnt : fetch_left) - 1'b1;
      end
      if (issue)         pre_valid <= 1'b1;
      else if (load_cur) pre_valid <= 1'b0;
    end
  end

  ///////////////////////////////////////////////////
  // 128 to 32 splitter
  ///////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (load_cur)  cur_data <= pre_data;
    else if (xfer) cur_data <= cur_data >> chan_pkg::word_w; // bits 31:0 go first
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      cur_valid <= 1'b0;
      word_idx  <= '0;
    end else begin
      if (load_cur) begin
        cur_valid <= 1'b1;
        word_idx  <= '0;
      end else if (xfer) begin
        word_idx <= word_idx + 1'b1;
        if (word_end) cur_valid <= 1'b0; // nothing prefetched, wait for memory
      end
    end
  end

  assign fill_link.valid = cur_valid;
  assign fill_link.data  = cur_data[chan_pkg::word_w-1:0];
  // final burst once nothing is prefetched or left to fetch
  assign fill_link.last  = (word_idx == chan_pkg::last_word) && !pre_valid && (fetch_left == '0);
  assign reading_done    = xfer && fill_link.last;

endmodule

// ==== design/command_proc.sv ====
`timescale 1ns/100ps

module command_proc (
  input  logic                             clk125,
  input  logic                             arst_n,
  input  logic [chan_pkg::word_w-1:0]      rx_data,
  input  logic                             rx_valid,
  input  logic                             rx_last,
  output logic                             rx_ready,
  link_if.src                              cmd_link,
  output logic                             read_start,   // one cycle, header transfer
  output logic [chan_pkg::mem_addr_w-1:0]  start_addr,
  output logic [chan_pkg::burst_cnt_w-1:0] burst_cnt,
  input  logic                             reading_done, // final fill word went out
  output logic                             use_fill_data
);

  typedef enum logic [1:0] {
    st_idle,    // waiting for a command word
    st_respond, // response word on cmd_link
    st_fill     // link handed to the fill reader
  } state_t;

  state_t                           state;
  logic                             mid_packet;  // inside a multi-word rx packet
  logic [chan_pkg::tag_w-1:0]       channel_tag;
  logic [chan_pkg::word_w-1:0]      resp_data;
  logic                             resp_last;
  logic                             rx_accept;
  logic                             new_cmd;
  logic                             hdr_xfer;
  logic [chan_pkg::op_w-1:0]        opcode;
  logic [chan_pkg::burst_cnt_w-1:0] rx_cnt;
  logic [chan_pkg::word_w-1:0]      tag_word;
  logic [chan_pkg::word_w-1:0]      fill_word;

  ///////////////////////////////////////////////////
  // decode
  ///////////////////////////////////////////////////
  assign rx_ready  = (state == st_idle); // low until the response is done
  assign rx_accept = rx_valid && rx_ready;
  assign new_cmd   = rx_accept && !mid_packet; // only the first word of a packet is a command
  assign opcode    = rx_data[chan_pkg::op_lo +: chan_pkg::op_w];
  assign rx_cnt    = rx_data[chan_pkg::cnt_lo +: chan_pkg::burst_cnt_w];

  // response words, built from the current tag
  always_comb begin
    tag_word  = '0;
    tag_word[chan_pkg::op_lo +: chan_pkg::op_w]   = chan_pkg::resp_tag;
    tag_word[chan_pkg::tag_lo +: chan_pkg::tag_w] = channel_tag;
    fill_word = '0;
    fill_word[chan_pkg::op_lo +: chan_pkg::op_w]       = chan_pkg::resp_fill;
    fill_word[chan_pkg::hdr_tag_lo +: chan_pkg::tag_w] = channel_tag;
    fill_word[chan_pkg::cnt_lo +: chan_pkg::burst_cnt_w] = rx_cnt;
  end

  ///////////////////////////////////////////////////
  // control FSM
  ///////////////////////////////////////////////////
  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= st_idle;
      mid_packet  <= 1'b0;
      channel_tag <= '0;
    end else begin
      if (rx_accept) begin
        mid_packet <= !rx_last; // trailing words are dropped
      end
      case (state)
        st_idle: begin
          if (new_cmd) begin
            if (opcode == chan_pkg::op_write_tag) begin
              channel_tag <= rx_data[chan_pkg::tag_lo +: chan_pkg::tag_w]; // silent
            end
            if (opcode == chan_pkg::op_read_tag || opcode == chan_pkg::op_read_fill) begin
              state <= st_respond;
            end
            // anything else falls through with no reply
          end
        end
        st_respond: begin
          if (cmd_link.valid && cmd_link.ready) begin
            state <= resp_last ? st_idle : st_fill;
          end
        end
        st_fill: begin
          if (reading_done) state <= st_idle; // hand the link back
        end
        default: state <= st_idle;
      endcase
    end
  end

  // response word and readout request, loaded when the command is taken
  always_ff @(posedge clk125) begin
    if (new_cmd) begin
      resp_data <= (opcode == chan_pkg::op_read_fill) ? fill_word : tag_word;
      resp_last <= (opcode != chan_pkg::op_read_fill); // fill header is not the end
      if (opcode == chan_pkg::op_read_fill) begin
        start_addr <= rx_data[chan_pkg::addr_lo +: chan_pkg::mem_addr_w];
        burst_cnt  <= rx_cnt;
      end
    end
  end

  ///////////////////////////////////////////////////
  // link side
  ///////////////////////////////////////////////////
  assign cmd_link.valid = (state == st_respond); // held through back-pressure
  assign cmd_link.data  = resp_data;
  assign cmd_link.last  = resp_last;

  assign hdr_xfer      = cmd_link.valid && cmd_link.ready && !resp_last;
  assign read_start    = hdr_xfer;             // reader starts as the header leaves
  assign use_fill_data = (state == st_fill);   // rises on the header edge

endmodule

// ==== design/link_if.sv ====
`timescale 1ns/100ps

// 32-bit link stream, one word moves when valid and ready are both high
interface link_if;

  logic [chan_pkg::word_w-1:0] data;
  logic                        valid;
  logic                        last;  // final word of a response
  logic                        ready;

  modport src (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport snk (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// ==== design/chan_pkg.sv ====
package chan_pkg;

  ///////////////////////////////////////////////////
  // widths and depths
  ///////////////////////////////////////////////////
  localparam int word_w          = 32;  // link word
  localparam int burst_w         = 128; // one fill memory burst
  localparam int words_per_burst = burst_w / word_w;
  localparam int word_idx_w      = 2;   // log2 of words_per_burst
  localparam int mem_addr_w      = 6;
  localparam int mem_depth       = 1 << mem_addr_w; // 64 bursts
  localparam int burst_cnt_w     = 7;   // 1..64 bursts per readout
  localparam int tag_w           = 16;

  // index of the final word inside a burst
  localparam logic [word_idx_w-1:0] last_word = word_idx_w'(words_per_burst - 1);

  ///////////////////////////////////////////////////
  // command and response word fields
  ///////////////////////////////////////////////////
  localparam int op_w       = 8;
  localparam int op_lo      = 24; // opcode in 31:24
  localparam int tag_lo     = 0;  // write_tag / resp_tag payload, 15:0
  localparam int addr_lo    = 16; // read_fill start address, 21:16
  localparam int cnt_lo     = 0;  // read_fill / resp_fill burst count, 6:0
  localparam int hdr_tag_lo = 8;  // tag inside the resp_fill header, 23:8

  // received opcodes
  localparam logic [op_w-1:0] op_write_tag = 8'h01;
  localparam logic [op_w-1:0] op_read_tag  = 8'h02;
  localparam logic [op_w-1:0] op_read_fill = 8'h03;

  // response opcodes, msb set to mark link replies
  localparam logic [op_w-1:0] resp_tag  = 8'h82;
  localparam logic [op_w-1:0] resp_fill = 8'h83;

endpackage
